// ==== include/fp_add_settings.svh ====
`ifndef FP_ADD_SETTINGS_SVH
`define FP_ADD_SETTINGS_SVH

// binary16 field widths
`define FP_EXP_WIDTH   5
`define FP_MNTS_WIDTH  10 // stored bits, hidden one not counted

// guard, round and sticky below the mantissa lsb
`define FP_GRS_WIDTH   3

// sign + exponent + mantissa
`define FP_WORD_WIDTH  (1 + `FP_EXP_WIDTH + `FP_MNTS_WIDTH)

// all-ones exponent, reserved for infinity
`define FP_EXP_MAX     ((1 << `FP_EXP_WIDTH) - 1)

`endif

// ==== design/fp_add_pkg.sv ====
`include "fp_add_settings.svh"

package fp_add_pkg;

	typedef logic [`FP_EXP_WIDTH-1:0] exp_t;
	typedef logic [`FP_EXP_WIDTH:0]   exp_ext_t; // extra msb catches carry or borrow

	typedef logic [`FP_MNTS_WIDTH-1:0] mnts_t;

	// hidden one, stored mantissa, then g r s
	typedef logic [`FP_MNTS_WIDTH+`FP_GRS_WIDTH:0] ext_mnts_t;

	// adder result, one carry bit on top of ext_mnts_t
	typedef logic [`FP_MNTS_WIDTH+`FP_GRS_WIDTH+1:0] sum_mnts_t;

	// packed word, msb first
	typedef struct packed {
		logic  sign;
		exp_t  exp;
		mnts_t mnts;
	} fp_word_t;

	typedef enum logic {
		FP_OP_ADD = 1'b0,
		FP_OP_SUB = 1'b1
	} fp_op_e;

	// post-add normalization direction
	typedef enum logic [1:0] {
		NORM_LEFT  = 2'd0, // leading zeros, shift up
		NORM_RIGHT = 2'd1, // mantissa carry, shift down by one
		NORM_ZERO  = 2'd2  // exact cancellation
	} norm_e;

endpackage

// ==== design/fp_align.sv ====
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_align (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_valid,
	input  fp_add_pkg::fp_op_e    i_op,
	input  fp_add_pkg::fp_word_t  i_a,
	input  fp_add_pkg::fp_word_t  i_b,
	output logic                  o_valid,
	output logic                  o_sign,
	output fp_add_pkg::exp_t      o_exp,
	output fp_add_pkg::ext_mnts_t o_large_mnts,
	output fp_add_pkg::ext_mnts_t o_small_mnts,
	output logic                  o_eff_sub
);
	import fp_add_pkg::*;

	localparam int PRE_W     = `FP_MNTS_WIDTH + `FP_GRS_WIDTH; // hidden + mnts + g + r
	localparam int MAX_SHIFT = PRE_W + 1; // from here on only the sticky survives

	fp_word_t         b_signed; // b after the opcode is applied
	fp_word_t         large_op;
	fp_word_t         small_op;
	logic             a_ge_b;
	exp_t             exp_diff;
	logic [PRE_W-1:0] small_pre;
	logic [2*PRE_W-1:0] small_shifted; // lower half collects the bits shifted out
	logic             sticky;

	always_comb begin
		b_signed      = i_b;
		b_signed.sign = i_b.sign ^ (i_op == FP_OP_SUB); // a - b == a + (-b)
	end

	// magnitude compare, exponent first then mantissa, a wins ties
	assign a_ge_b   = {i_a.exp, i_a.mnts} >= {b_signed.exp, b_signed.mnts};
	assign large_op = a_ge_b ? i_a : b_signed;
	assign small_op = a_ge_b ? b_signed : i_a;
	assign exp_diff = large_op.exp - small_op.exp; // never negative after the swap

	assign small_pre = {1'b1, small_op.mnts, 2'b00}; // g and r start empty

	always_comb begin
		if (exp_diff >= exp_t'(MAX_SHIFT)) begin
			small_shifted = '0;
			sticky        = 1'b1; // hidden one is somewhere below r
		end else begin
			small_shifted = {small_pre, {PRE_W{1'b0}}} >> exp_diff;
			sticky        = |small_shifted[PRE_W-1:0]; // every bit that fell below r
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// payload, held between operations
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_sign       <= large_op.sign; // result sign follows the larger magnitude
			o_exp        <= large_op.exp;
			o_large_mnts <= {1'b1, large_op.mnts, {`FP_GRS_WIDTH{1'b0}}};
			o_small_mnts <= {small_shifted[2*PRE_W-1:PRE_W], sticky};
			o_eff_sub    <= i_a.sign ^ b_signed.sign;
		end
	end

	// zero, subnormal, inf and nan are outside the supported range
	a_normal_operands : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_valid |-> (i_a.exp != '0) && (i_a.exp != exp_t'(`FP_EXP_MAX)) &&
			(i_b.exp != '0) && (i_b.exp != exp_t'(`FP_EXP_MAX)))
		else $error("fp_align: operand exponent outside 1..30");

endmodule

// ==== design/fp_mnts_addsub.sv ====
`timescale 1ns/1ps

module fp_mnts_addsub (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_valid,
	input  logic                  i_sign,
	input  fp_add_pkg::exp_t      i_exp,
	input  fp_add_pkg::ext_mnts_t i_large_mnts,
	input  fp_add_pkg::ext_mnts_t i_small_mnts,
	input  logic                  i_eff_sub,
	output logic                  o_valid,
	output logic                  o_sign,
	output fp_add_pkg::exp_t      o_exp,
	output fp_add_pkg::sum_mnts_t o_sum
);
	import fp_add_pkg::*;

	sum_mnts_t sum; // top bit is the carry

	// sign-magnitude, large minus small never goes negative
	always_comb begin
		if (i_eff_sub) begin
			sum = {1'b0, i_large_mnts} - {1'b0, i_small_mnts};
		end else begin
			sum = {1'b0, i_large_mnts} + {1'b0, i_small_mnts};
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_sign <= i_sign;
			o_exp  <= i_exp;
			o_sum  <= sum;
		end
	end

	// relies on the magnitude ordering done one stage earlier
	a_sub_no_carry : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_valid && i_eff_sub) |-> !sum[$bits(sum_mnts_t)-1])
		else $error("fp_mnts_addsub: carry out of a subtraction");

endmodule

// ==== design/fp_normalize.sv ====
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_normalize (
	input  logic                                       i_clk,
	input  logic                                       i_arst_n,
	input  logic                                       i_valid,
	input  logic                                       i_sign,
	input  fp_add_pkg::exp_t                           i_exp,
	input  fp_add_pkg::sum_mnts_t                      i_sum,
	output logic                                       o_valid,
	output logic                                       o_sign,
	output fp_add_pkg::exp_t                           o_exp,
	output logic [`FP_MNTS_WIDTH+`FP_GRS_WIDTH-1:0]    o_mnts,
	output logic                                       o_underflow,
	output logic                                       o_zero
);
	import fp_add_pkg::*;

	localparam int SUM_MSB = `FP_MNTS_WIDTH + `FP_GRS_WIDTH; // hidden bit position
	localparam int LZ_W    = $clog2(SUM_MSB + 1);

	norm_e              norm_dir;
	logic [LZ_W-1:0]    lz_cnt;
	logic [SUM_MSB-1:0] left_body; // hidden..r shifted up, sticky kept apart
	exp_ext_t           exp_adj;
	logic [SUM_MSB-1:0] mnts_norm;
	logic               uflow;

	// priority on carry, then zero
	always_comb begin
		if (i_sum[SUM_MSB+1]) begin
			norm_dir = NORM_RIGHT;
		end else if (i_sum == '0) begin
			norm_dir = NORM_ZERO;
		end else begin
			norm_dir = NORM_LEFT;
		end
	end

	// leading zero count below the carry bit, highest set bit wins
	always_comb begin
		lz_cnt = '0;
		for (int i = 0; i <= SUM_MSB; i++) begin
			if (i_sum[i]) lz_cnt = LZ_W'(SUM_MSB - i);
		end
	end

	assign left_body = i_sum[SUM_MSB:1] << lz_cnt; // zeros shifted into r

	always_comb begin
		exp_adj   = '0;
		mnts_norm = '0;
		uflow     = 1'b0;
		case (norm_dir)
			NORM_RIGHT: begin
				exp_adj   = {1'b0, i_exp} + exp_ext_t'(1);
				// old r and s fold into the new sticky
				mnts_norm = {i_sum[SUM_MSB:2], |i_sum[1:0]};
			end
			NORM_LEFT: begin
				exp_adj   = {1'b0, i_exp} - exp_ext_t'(lz_cnt);
				mnts_norm = {left_body[SUM_MSB-2:0], i_sum[0]}; // drop hidden bit
				// borrow or exponent zero, below the smallest normal
				uflow     = exp_adj[`FP_EXP_WIDTH] || (exp_adj == '0);
			end
			default: begin
				exp_adj   = '0; // exact cancellation
				mnts_norm = '0;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_sign      <= i_sign;
			o_exp       <= exp_adj[`FP_EXP_WIDTH-1:0]; // msb only mattered for the borrow
			o_mnts      <= mnts_norm;
			o_underflow <= uflow;
			o_zero      <= (norm_dir == NORM_ZERO);
		end
	end

endmodule

// ==== design/fp_round.sv ====
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_round (
	input  logic                                    i_clk,
	input  logic                                    i_arst_n,
	input  logic                                    i_valid,
	input  logic                                    i_sign,
	input  fp_add_pkg::exp_t                        i_exp,
	input  logic [`FP_MNTS_WIDTH+`FP_GRS_WIDTH-1:0] i_mnts,
	input  logic                                    i_underflow,
	input  logic                                    i_zero,
	output logic                                    o_valid,
	output fp_add_pkg::fp_word_t                    o_y,
	output logic                                    o_overflow,
	output logic                                    o_underflow
);
	import fp_add_pkg::*;

	localparam int MW = `FP_MNTS_WIDTH;
	localparam int GW = `FP_GRS_WIDTH;

	logic                        round_up;
	logic [MW:0]                 mnts_inc; // msb is the rounding carry
	mnts_t                       mnts_fin;
	exp_ext_t                    exp_rnd;
	logic                        ovf;
	logic [`FP_WORD_WIDTH-1:0]   y_next;

	// nearest even, l = mantissa lsb, then g r s
	assign round_up = i_mnts[GW-1] & (i_mnts[GW] | i_mnts[GW-2] | i_mnts[GW-3]);
	assign mnts_inc = {1'b0, i_mnts[MW+GW-1:GW]} + (MW+1)'(round_up);

	// 1.11..1 + ulp becomes 10.0..0, shift back down one place
	assign mnts_fin = mnts_inc[MW] ? {1'b0, mnts_inc[MW-1:1]} : mnts_inc[MW-1:0];
	assign exp_rnd  = {1'b0, i_exp} + exp_ext_t'(mnts_inc[MW]);

	// flushed results carry a meaningless exponent
	assign ovf = !(i_underflow || i_zero) && (exp_rnd >= exp_ext_t'(`FP_EXP_MAX));

	always_comb begin
		if (ovf) begin
			y_next = {i_sign, exp_t'(`FP_EXP_MAX), {MW{1'b0}}}; // signed infinity
		end else if (i_underflow || i_zero) begin
			y_next = {i_sign, {`FP_EXP_WIDTH{1'b0}}, {MW{1'b0}}}; // signed zero
		end else begin
			y_next = {i_sign, exp_rnd[`FP_EXP_WIDTH-1:0], mnts_fin};
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid     <= 1'b0;
			o_overflow  <= 1'b0;
			o_underflow <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_overflow  <= ovf;
				o_underflow <= i_underflow; // exact zero is not an underflow
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) o_y <= fp_word_t'(y_next);
	end

	a_flags_exclusive : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_overflow && o_underflow))
		else $error("fp_round: overflow and underflow both set");

endmodule

// ==== design/fp_add_top.sv ====
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module fp_add_top (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  logic                 i_valid,
	input  fp_add_pkg::fp_op_e   i_op,
	input  fp_add_pkg::fp_word_t i_a,
	input  fp_add_pkg::fp_word_t i_b,
	output logic                 o_valid,
	output fp_add_pkg::fp_word_t o_y,
	output logic                 o_overflow,
	output logic                 o_underflow
);
	import fp_add_pkg::*;

	// stage 1 to 2
	logic      s1_valid;
	logic      s1_sign;
	exp_t      s1_exp;
	ext_mnts_t s1_large_mnts;
	ext_mnts_t s1_small_mnts;
	logic      s1_eff_sub;

	// stage 2 to 3
	logic      s2_valid;
	logic      s2_sign;
	exp_t      s2_exp;
	sum_mnts_t s2_sum;

	// stage 3 to 4, mantissa without hidden bit
	logic                                    s3_valid;
	logic                                    s3_sign;
	exp_t                                    s3_exp;
	logic [`FP_MNTS_WIDTH+`FP_GRS_WIDTH-1:0] s3_mnts;
	logic                                    s3_underflow;
	logic                                    s3_zero;

	fp_align u_align (.i_clk, .i_arst_n, .i_valid, .i_op, .i_a, .i_b,
		.o_valid(s1_valid), .o_sign(s1_sign), .o_exp(s1_exp),
		.o_large_mnts(s1_large_mnts), .o_small_mnts(s1_small_mnts), .o_eff_sub(s1_eff_sub));

	fp_mnts_addsub u_addsub (.i_clk, .i_arst_n, .i_valid(s1_valid), .i_sign(s1_sign),
		.i_exp(s1_exp), .i_large_mnts(s1_large_mnts), .i_small_mnts(s1_small_mnts),
		.i_eff_sub(s1_eff_sub), .o_valid(s2_valid), .o_sign(s2_sign), .o_exp(s2_exp),
		.o_sum(s2_sum));

	fp_normalize u_normalize (.i_clk, .i_arst_n, .i_valid(s2_valid), .i_sign(s2_sign),
		.i_exp(s2_exp), .i_sum(s2_sum), .o_valid(s3_valid), .o_sign(s3_sign), .o_exp(s3_exp),
		.o_mnts(s3_mnts), .o_underflow(s3_underflow), .o_zero(s3_zero));

	fp_round u_round (.i_clk, .i_arst_n, .i_valid(s3_valid), .i_sign(s3_sign),
		.i_exp(s3_exp), .i_mnts(s3_mnts), .i_underflow(s3_underflow), .i_zero(s3_zero),
		.o_valid, .o_y, .o_overflow, .o_underflow);

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset low from time zero, released just after an edge
	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#2 o_arst_n = 1'b1;
	end

endmodule

// ==== bench/tb_fp_add.sv ====
`timescale 1ns/1ps
`include "fp_add_settings.svh"

module tb_fp_add;
	import fp_add_pkg::*;

	localparam int CLK_NS    = 40;
	localparam int NUM_TESTS = 6;
	localparam int RAND_OPS  = 300;
	localparam int NUM_OPS   = 5 + 8 + 9 + 6 + 5 + RAND_OPS; // directed ops plus the stream

	typedef struct packed {
		logic [15:0] y;
		logic        ovf;
		logic        unf;
	} result_t;

	logic       clk;
	logic       arst_n;
	logic       valid;
	fp_op_e     op;
	fp_word_t   a;
	fp_word_t   b;
	logic       y_valid;
	fp_word_t   y;
	logic       overflow;
	logic       underflow;
	integer     seed;
	result_t    exp_q[$]; // expected results, oldest first
	logic [3:0] vld_hist; // one bit per pipeline stage

	tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clk_gen (
		.o_clk(clk), .o_arst_n(arst_n));

	fp_add_top DUT (.i_clk(clk), .i_arst_n(arst_n), .i_valid(valid), .i_op(op), .i_a(a),
		.i_b(b), .o_valid(y_valid), .o_y(y), .o_overflow(overflow), .o_underflow(underflow));

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, name,
			expected, actual));
	endtask

	// exact integer sum in units of 2^-24, then round to 11 significant bits
	function automatic result_t expected_sum(input fp_op_e op_in, input logic [15:0] a_in,
		input logic [15:0] b_in);
		longint  va;
		longint  vb;
		longint  sum;
		longint  mag;
		longint  keep;
		longint  rem;
		longint  half;
		int      p;
		int      shift;
		int      bexp;
		logic    sign_b;
		logic    sign_r;
		result_t r;
		r.ovf  = 1'b0;
		r.unf  = 1'b0;
		sign_b = b_in[15] ^ (op_in == FP_OP_SUB);
		va = longint'({1'b1, a_in[9:0]}) << (int'(a_in[14:10]) - 1);
		vb = longint'({1'b1, b_in[9:0]}) << (int'(b_in[14:10]) - 1);
		if (a_in[15]) va = -va;
		if (sign_b) vb = -vb;
		sum = va + vb;
		if (sum == 64'sd0) begin
			r.y = {a_in[15], 15'd0}; // only equal magnitudes cancel, a wins the tie
			return r;
		end
		sign_r = (sum < 64'sd0);
		mag    = sign_r ? -sum : sum;
		p      = 0;
		for (int i = 0; i < 42; i++) begin
			if (mag[i]) p = i;
		end
		if (p < 10) begin
			r.y   = {sign_r, 15'd0}; // below 2^-14
			r.unf = 1'b1;
			return r;
		end
		shift = p - 10;
		keep  = mag >> shift;
		rem   = mag - (keep << shift);
		half  = (shift > 0) ? (longint'(1) << (shift - 1)) : 64'sd0;
		if (shift > 0 && (rem > half || (rem == half && keep[0]))) keep++;
		if (keep == 64'sd2048) begin
			keep = 64'sd1024; // rounding carried into a new binade
			p++;
		end
		bexp = p - 9;
		if (bexp >= `FP_EXP_MAX) begin
			r.y   = {sign_r, 5'(`FP_EXP_MAX), 10'd0};
			r.ovf = 1'b1;
		end else begin
			r.y = {sign_r, 5'(bexp), keep[9:0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] rand_operand(input int near_exp);
		int r;
		int m;
		int e;
		r = $random(seed) & 32'h7fff_ffff;
		m = $random(seed);
		if (near_exp == 0) begin
			e = 1 + r % 30;
		end else begin
			e = near_exp + r % 7 - 3; // close exponents, lots of cancellation
			if (e < 1) e = 1;
			if (e > 30) e = 30;
		end
		return {m[15], 5'(e), m[9:0]};
	endfunction

	task automatic send_op(input fp_op_e op_in, input logic [15:0] a_in,
		input logic [15:0] b_in);
		@(posedge clk);
		#2;
		valid = 1'b1;
		op    = op_in;
		a     = a_in;
		b     = b_in;
		exp_q.push_back(expected_sum(op_in, a_in, b_in));
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2 valid = 1'b0;
	endtask

	// wait until every queued result has been checked
	task automatic drain();
		idle_cycle();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic same_sign_adds();
		send_op(FP_OP_ADD, 16'h3e00, 16'h3e00); // 1.5 + 1.5, carry out
		send_op(FP_OP_ADD, 16'h3c00, 16'h3800); // 1.0 + 0.5
		send_op(FP_OP_ADD, 16'h3c00, 16'h3c00);
		send_op(FP_OP_ADD, 16'hc000, 16'hc200); // -2 + -3
		send_op(FP_OP_ADD, 16'h57ff, 16'h5001);
		drain();
	endtask

	task automatic subtractions();
		send_op(FP_OP_SUB, 16'h3c00, 16'h3800);
		send_op(FP_OP_ADD, 16'h3c00, 16'hb800); // opposite signs
		send_op(FP_OP_SUB, 16'h3c01, 16'h3c00); // ten-place left shift
		send_op(FP_OP_SUB, 16'h3800, 16'h3c00); // b larger, sign flips
		send_op(FP_OP_SUB, 16'h3bff, 16'h3c00);
		send_op(FP_OP_SUB, 16'h4500, 16'h4500); // exact zero, +0
		send_op(FP_OP_ADD, 16'hc500, 16'h4500); // exact zero, -0 from a
		send_op(FP_OP_SUB, 16'h6400, 16'h63ff);
		drain();
	endtask

	task automatic rounding_cases();
		send_op(FP_OP_ADD, 16'h3c00, 16'h1000); // tie, stays even
		send_op(FP_OP_ADD, 16'h3c01, 16'h1000); // tie, up to even
		send_op(FP_OP_ADD, 16'h3c00, 16'h1001); // just above half
		send_op(FP_OP_ADD, 16'h3c00, 16'h0401); // diff 14, sticky only
		send_op(FP_OP_ADD, 16'h5400, 16'h0400); // diff 20
		send_op(FP_OP_SUB, 16'h5400, 16'h0401);
		send_op(FP_OP_ADD, 16'h3fff, 16'h1000); // rounding carry renormalizes
		send_op(FP_OP_ADD, 16'h4000, 16'h0c00); // diff 13
		send_op(FP_OP_SUB, 16'h3c00, 16'h0c01); // diff 12
		drain();
	endtask

	task automatic overflow_cases();
		send_op(FP_OP_ADD, 16'h7bff, 16'h7bff);
		send_op(FP_OP_ADD, 16'h7800, 16'h7800);
		send_op(FP_OP_ADD, 16'hf800, 16'hf800); // negative infinity
		send_op(FP_OP_ADD, 16'h7bff, 16'h4c00); // tie rounds up into infinity
		send_op(FP_OP_ADD, 16'h7bff, 16'h4bff); // just under the tie
		send_op(FP_OP_SUB, 16'h7bff, 16'hfbff);
		drain();
	endtask

	task automatic underflow_cases();
		send_op(FP_OP_SUB, 16'h0401, 16'h0400);
		send_op(FP_OP_SUB, 16'h0400, 16'h0401); // negative zero
		send_op(FP_OP_SUB, 16'h0801, 16'h0800);
		send_op(FP_OP_SUB, 16'h0800, 16'h0401);
		send_op(FP_OP_ADD, 16'h0bff, 16'h8800); // lands on the smallest binade
		drain();
	endtask

	task automatic random_stream(input int n_ops);
		int          issued;
		int          pick;
		logic [15:0] ra;
		logic [15:0] rb;
		issued = 0;
		while (issued < n_ops) begin
			pick = $random(seed);
			if (pick[2:0] == 3'd0) begin
				idle_cycle(); // gap in the stream
			end else begin
				ra = rand_operand(0);
				rb = rand_operand(pick[3] ? int'(ra[14:10]) : 0);
				send_op(pick[4] ? FP_OP_SUB : FP_OP_ADD, ra, rb);
				issued++;
			end
		end
		drain();
	endtask

	// which input edges carried an operation
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) vld_hist <= '0;
		else vld_hist <= {vld_hist[2:0], valid};
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		result_t expv;
		assert (y_valid == vld_hist[3])
			else report_value("o_valid", 16'(vld_hist[3]), 16'(y_valid));
		if (vld_hist[3]) begin
			expv = exp_q.pop_front();
			assert (y == expv.y) else report_value("o_y", expv.y, y);
			assert (overflow == expv.ovf)
				else report_value("o_overflow", 16'(expv.ovf), 16'(overflow));
			assert (underflow == expv.unf)
				else report_value("o_underflow", 16'(expv.unf), 16'(underflow));
		end
	end

	initial begin
		#((NUM_OPS + 4 * NUM_TESTS + 20) * CLK_NS * 2);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		seed  = 32'he30a;
		valid = 1'b0;
		op    = FP_OP_ADD;
		a     = 16'h3c00;
		b     = 16'h3c00;
		wait (arst_n === 1'b1);
		same_sign_adds();
		subtractions();
		rounding_cases();
		overflow_cases();
		underflow_cases();
		random_stream(RAND_OPS);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
design/fp_add_pkg.sv
design/fp_align.sv
design/fp_mnts_addsub.sv
design/fp_normalize.sv
design/fp_round.sv
design/fp_add_top.sv
bench/tb_clock_gen.sv
bench/tb_fp_add.sv

// ==== Makefile ====
# Verilator build and run of the binary16 adder testbench

SRCS := $(filter-out +%,$(shell cat files.f)) include/fp_add_settings.svh

.PHONY: run clean

run: obj_dir/Vtb_fp_add
	@out="$$(./obj_dir/Vtb_fp_add)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

obj_dir/Vtb_fp_add: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module tb_fp_add -j 0

clean:
	rm -rf obj_dir
